/* Makefile */
VERILATOR  ?= verilator
TOP        ?= alu_tb
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/alu_commit_if.sv */
// Execute to result commit bus
`timescale 1ns/1ps

interface alu_commit_if;
    import alu_pkg::*;

    logic  commit_valid;
    data_t data;        // Sized, zero above the op size.
    ccr_t  flags;
    ccr_t  flag_mask;   // Set bits are written into the CCR.

    modport exe (
        output commit_valid, data, flags, flag_mask
    );

    modport res (
        input commit_valid, data, flags, flag_mask
    );

endinterface

/* design/alu_core.sv */
// ALU pipeline top level
`timescale 1ns/1ps

module alu_core (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              op_valid,
    input  alu_pkg::op_code_t op_code,
    input  alu_pkg::op_size_t op_size,
    input  alu_pkg::data_t    op_src,
    input  alu_pkg::data_t    op_dst,
    input  alu_pkg::cond_t    op_cond,
    input  logic              result_credit,
    output logic              op_ready,
    output logic              result_valid,
    output alu_pkg::data_t    result_data,
    output alu_pkg::ccr_t     ccr
);

    alu_issue_if  issue_bus ();
    alu_commit_if commit_bus ();

    // Accept, count credits, register the op.
    alu_decode u_decode (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_size       (op_size),
        .op_src        (op_src),
        .op_dst        (op_dst),
        .op_cond       (op_cond),
        .result_credit (result_credit),
        .op_ready      (op_ready),
        .issue         (issue_bus.dec)
    );

    // Combinational. Reads the CCR of the previous op.
    alu_execute u_execute (
        .issue  (issue_bus.exe),
        .ccr    (ccr),
        .commit (commit_bus.exe)
    );

    alu_result u_result (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .commit       (commit_bus.res),
        .result_valid (result_valid),
        .result_data  (result_data),
        .ccr          (ccr)
    );

endmodule

/* design/alu_decode.sv */
// ALU decode stage
`timescale 1ns/1ps

module alu_decode (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              op_valid,
    input  alu_pkg::op_code_t op_code,
    input  alu_pkg::op_size_t op_size,
    input  alu_pkg::data_t    op_src,
    input  alu_pkg::data_t    op_dst,
    input  alu_pkg::cond_t    op_cond,
    input  logic              result_credit,
    output logic              op_ready,
    alu_issue_if.dec          issue
);
    import alu_pkg::*;

    credit_t credit_cnt;  // Free result slots at the consumer.
    logic    accept;

    // ==================================================================
    // Credit counter
    // ==================================================================
    assign op_ready = (credit_cnt != '0);
    assign accept   = op_valid && op_ready;

    always_ff @(posedge CLK or negedge rst_n) begin : credit_count
        if (!rst_n) begin
            credit_cnt <= CREDIT_MAX;
        end else begin
            // Accept and return in one cycle cancel out.
            case ({accept, result_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ==================================================================
    // Issue register
    // ==================================================================
    always_ff @(posedge CLK or negedge rst_n) begin : issue_strobe
        if (!rst_n) begin
            issue.issue_valid <= 1'b0;
        end else begin
            issue.issue_valid <= accept;  // Low when nothing accepted.
        end
    end

    // Op payload, loaded only on acceptance.
    always_ff @(posedge CLK) begin : issue_payload
        if (accept) begin
            issue.code <= op_code;
            issue.size <= op_size;
            issue.dst  <= op_dst;
            if (op_code == OP_SCC) begin
                issue.src <= data_t'(op_cond);  // Condition rides in src.
            end else begin
                issue.src <= op_src;
            end
        end
    end

endmodule

/* design/alu_execute.sv */
// ALU execute datapath
`timescale 1ns/1ps

module alu_execute (
    alu_issue_if.exe      issue,
    input  alu_pkg::ccr_t ccr,
    alu_commit_if.exe     commit
);
    import alu_pkg::*;

    data_t       size_mask;
    data_t       src_sx;
    data_t       dst_sx;
    data_t       src_m;
    data_t       dst_m;
    data_t       result;
    data_t       res_sx;
    logic        res_zero;
    logic [32:0] arith_raw;
    logic        arith_carry;
    logic        arith_ovf;
    logic [7:0]  bcd_result;
    logic        bcd_carry;
    cond_t       scc_cond;
    logic        cond_true;
    ccr_t        new_flags;
    ccr_t        new_mask;

    function automatic data_t sign_ext(input data_t d, input op_size_t s);
        case (s)
            SIZE_BYTE: return {{24{d[7]}}, d[7:0]};
            SIZE_WORD: return {{16{d[15]}}, d[15:0]};
            default:   return d;
        endcase
    endfunction

    // One BCD digit. Returns {carry or borrow, digit}.
    function automatic logic [4:0] bcd_digit(input logic [3:0] a, input logic [3:0] b,
                                             input logic cin, input logic sub);
        logic [4:0] raw;
        logic       adj;
        raw = sub ? ({1'b0, a} - {1'b0, b} - {4'b0, cin})
                  : ({1'b0, a} + {1'b0, b} + {4'b0, cin});
        adj = (raw > BCD_DIGIT_MAX);
        if (!adj) return {1'b0, raw[3:0]};
        return {1'b1, sub ? raw[3:0] - BCD_CORRECTION : raw[3:0] + BCD_CORRECTION};
    endfunction

    // ==================================================================
    // Operand sizing
    // ==================================================================
    always_comb begin : sizing
        case (issue.size)
            SIZE_BYTE: size_mask = 32'h0000_00FF;
            SIZE_WORD: size_mask = 32'h0000_FFFF;
            default:   size_mask = 32'hFFFF_FFFF;
        endcase
    end

    assign src_sx = sign_ext(issue.src, issue.size);
    assign dst_sx = sign_ext(issue.dst, issue.size);
    assign src_m  = src_sx & size_mask;
    assign dst_m  = dst_sx & size_mask;

    // ==================================================================
    // Integer arithmetic
    // ==================================================================
    always_comb begin : arith
        logic        x_in;
        logic        is_sub;
        logic [32:0] a;
        logic [32:0] b;
        logic        a_msb;
        logic        b_msb;
        x_in   = (issue.code == OP_ADDX || issue.code == OP_SUBX) ? ccr[CCR_X] : 1'b0;
        is_sub = issue.code inside {OP_SUB, OP_SUBX, OP_CMP, OP_NEG};
        a      = (issue.code == OP_NEG) ? 33'd0 : {1'b0, dst_m};  // NEG is 0 - dst.
        b      = (issue.code == OP_NEG) ? {1'b0, dst_m} : {1'b0, src_m};
        a_msb  = (issue.code == OP_NEG) ? 1'b0 : dst_sx[31];
        b_msb  = (issue.code == OP_NEG) ? dst_sx[31] : src_sx[31];
        arith_raw = is_sub ? (a - b - {32'd0, x_in}) : (a + b + {32'd0, x_in});
        case (issue.size)
            SIZE_BYTE: arith_carry = arith_raw[8];
            SIZE_WORD: arith_carry = arith_raw[16];
            default:   arith_carry = arith_raw[32];
        endcase
        // Signed overflow from the operand and result signs.
        arith_ovf = (is_sub ? (a_msb != b_msb) : (a_msb == b_msb)) && (res_sx[31] != a_msb);
    end

    // BCD, digit by digit with the decimal carry chained.
    always_comb begin : bcd_op
        logic [4:0] lo;
        logic [4:0] hi;
        lo = bcd_digit(dst_m[3:0], src_m[3:0], ccr[CCR_X], issue.code == OP_SBCD);
        hi = bcd_digit(dst_m[7:4], src_m[7:4], lo[4], issue.code == OP_SBCD);
        bcd_result = {hi[3:0], lo[3:0]};
        bcd_carry  = hi[4];
    end

    // ==================================================================
    // Condition tests for Scc
    // ==================================================================
    assign scc_cond = cond_t'(issue.src[3:0]);

    always_comb begin : cond_eval
        logic nv;
        nv = ccr[CCR_N] ^ ccr[CCR_V];
        case (scc_cond)
            4'h0: cond_true = 1'b1;                     // T.
            4'h1: cond_true = 1'b0;                     // F.
            4'h2: cond_true = !(ccr[CCR_Z] | ccr[CCR_C]);  // HI.
            4'h3: cond_true = ccr[CCR_Z] | ccr[CCR_C];  // LS.
            4'h4: cond_true = !ccr[CCR_C];
            4'h5: cond_true = ccr[CCR_C];
            4'h6: cond_true = !ccr[CCR_Z];
            4'h7: cond_true = ccr[CCR_Z];
            4'h8: cond_true = !ccr[CCR_V];
            4'h9: cond_true = ccr[CCR_V];
            4'hA: cond_true = !ccr[CCR_N];              // PL.
            4'hB: cond_true = ccr[CCR_N];               // MI.
            4'hC: cond_true = !nv;                      // GE.
            4'hD: cond_true = nv;                       // LT.
            4'hE: cond_true = !ccr[CCR_Z] && !nv;       // GT.
            default: cond_true = ccr[CCR_Z] || nv;      // LE.
        endcase
    end

    // ==================================================================
    // Result select and flags
    // ==================================================================
    always_comb begin : result_mux
        case (issue.code)
            OP_AND:           result = dst_m & src_m;
            OP_OR:            result = dst_m | src_m;
            OP_EOR:           result = dst_m ^ src_m;
            OP_NOT:           result = ~dst_m & size_mask;
            OP_MOVE:          result = src_m;
            OP_ABCD, OP_SBCD: result = {24'd0, bcd_result};
            OP_SCC:           result = cond_true ? size_mask : '0;
            default:          result = arith_raw[31:0] & size_mask;
        endcase
    end

    assign res_sx   = sign_ext(result, issue.size);
    assign res_zero = (result == '0);

    always_comb begin : flag_gen
        new_flags = ccr;
        new_mask  = '0;
        case (issue.code)
            OP_ADD, OP_ADDX, OP_SUB, OP_SUBX, OP_CMP, OP_NEG: begin
                new_flags[CCR_X] = arith_carry;
                new_flags[CCR_N] = res_sx[31];
                new_flags[CCR_V] = arith_ovf;
                new_flags[CCR_C] = arith_carry;
                // Extended ops only ever clear Z.
                if (issue.code == OP_ADDX || issue.code == OP_SUBX) begin
                    new_flags[CCR_Z] = res_zero & ccr[CCR_Z];
                end else begin
                    new_flags[CCR_Z] = res_zero;
                end
                new_mask         = '1;
                new_mask[CCR_X]  = (issue.code != OP_CMP);
            end
            OP_AND, OP_OR, OP_EOR, OP_NOT, OP_MOVE: begin
                new_flags[CCR_N] = res_sx[31];
                new_flags[CCR_Z] = res_zero;
                new_flags[CCR_V] = 1'b0;
                new_flags[CCR_C] = 1'b0;
                new_mask         = '1;
                new_mask[CCR_X]  = 1'b0;   // X held.
            end
            OP_ABCD, OP_SBCD: begin
                new_flags[CCR_X] = bcd_carry;
                new_flags[CCR_Z] = res_zero & ccr[CCR_Z];
                new_flags[CCR_C] = bcd_carry;
                new_mask[CCR_X]  = 1'b1;
                new_mask[CCR_Z]  = 1'b1;
                new_mask[CCR_C]  = 1'b1;
            end
            default: new_mask = '0;  // Scc leaves the CCR alone.
        endcase
    end

    assign commit.commit_valid = issue.issue_valid;
    assign commit.data         = result;
    assign commit.flags        = new_flags;
    assign commit.flag_mask    = new_mask;

endmodule

/* design/alu_issue_if.sv */
// Decode to execute op bus
`timescale 1ns/1ps

interface alu_issue_if;
    import alu_pkg::*;

    logic     issue_valid;  // One cycle per accepted op.
    op_code_t code;
    op_size_t size;
    data_t    src;          // Holds the condition field in bits 3:0 for Scc.
    data_t    dst;

    modport dec (
        output issue_valid, code, size, src, dst
    );

    modport exe (
        input issue_valid, code, size, src, dst
    );

endinterface

/* design/alu_pkg.sv */
// ALU shared definitions
package alu_pkg;

    // ==================================================================
    // Types
    // ==================================================================
    typedef logic [31:0] data_t;     // Operand or result word.
    typedef logic [3:0]  op_code_t;
    typedef logic [1:0]  op_size_t;
    typedef logic [3:0]  cond_t;     // 68k condition field, T = 0 to LE = 15.
    typedef logic [4:0]  ccr_t;      // X N Z V C.
    typedef logic [1:0]  credit_t;

    // ==================================================================
    // Operation codes
    // ==================================================================
    // Integer arithmetic.
    localparam op_code_t OP_ADD  = 4'd0;
    localparam op_code_t OP_ADDX = 4'd1;
    localparam op_code_t OP_SUB  = 4'd2;
    localparam op_code_t OP_SUBX = 4'd3;
    localparam op_code_t OP_CMP  = 4'd4;
    localparam op_code_t OP_NEG  = 4'd5;

    // Logic.
    localparam op_code_t OP_AND  = 4'd6;
    localparam op_code_t OP_OR   = 4'd7;
    localparam op_code_t OP_EOR  = 4'd8;
    localparam op_code_t OP_NOT  = 4'd9;

    // Packed BCD, byte only.
    localparam op_code_t OP_ABCD = 4'd10;
    localparam op_code_t OP_SBCD = 4'd11;

    localparam op_code_t OP_MOVE = 4'd12;  // Flags as for TST.
    localparam op_code_t OP_SCC  = 4'd13;

    // ==================================================================
    // Operand sizes
    // ==================================================================
    // Same encoding as the 68k size field.
    localparam op_size_t SIZE_BYTE = 2'b00;
    localparam op_size_t SIZE_WORD = 2'b01;
    localparam op_size_t SIZE_LONG = 2'b10;

    // Bit positions inside ccr_t.
    localparam int CCR_X = 4;
    localparam int CCR_N = 3;
    localparam int CCR_Z = 2;
    localparam int CCR_V = 1;
    localparam int CCR_C = 0;

    // ==================================================================
    // Constants
    // ==================================================================
    // Largest legal BCD digit, and the nibble adjust above it.
    localparam logic [4:0] BCD_DIGIT_MAX  = 5'd9;
    localparam logic [3:0] BCD_CORRECTION = 4'd6;

    // Result slots owned by the consumer after reset.
    localparam credit_t CREDIT_MAX = 2'd2;

endpackage

/* design/alu_result.sv */
// ALU result stage
`timescale 1ns/1ps

module alu_result (
    input  logic           CLK,
    input  logic           rst_n,
    alu_commit_if.res      commit,
    output logic           result_valid,
    output alu_pkg::data_t result_data,
    output alu_pkg::ccr_t  ccr
);

    // One-cycle strobe, one edge after issue.
    always_ff @(posedge CLK or negedge rst_n) begin : valid_strobe
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= commit.commit_valid;
        end
    end

    // Result word and condition codes move together.
    always_ff @(posedge CLK or negedge rst_n) begin : result_regs
        if (!rst_n) begin
            result_data <= '0;
            ccr         <= '0;
        end else if (commit.commit_valid) begin
            result_data <= commit.data;
            // Only the bits the op owns change.
            ccr <= (ccr & ~commit.flag_mask) | (commit.flags & commit.flag_mask);
        end
    end

endmodule

/* dv/alu_core_properties.sv */
// ALU handshake and credit checks
`timescale 1ns/1ps

module alu_core_properties (
    input logic             CLK,
    input logic             rst_n,
    input logic             op_valid,
    input logic             op_ready,
    input logic             result_credit,
    input logic             result_valid,
    input alu_pkg::ccr_t    ccr,
    input alu_pkg::credit_t credit_cnt
);
    import alu_pkg::*;

    // No acceptance, so no result two edges later.
    result_needs_accept: assert property (@(posedge CLK) disable iff (!rst_n)
        !(op_valid && op_ready) |-> ##2 !result_valid)
        else $error("result_valid without a matching acceptance");

    // Two ops taken back to back with no credit back empty the pool.
    ready_needs_credit: assert property (@(posedge CLK) disable iff (!rst_n)
        (op_valid && op_ready && !result_credit)
        && $past(op_valid && op_ready && !result_credit) |=> !op_ready)
        else $error("op_ready high with no credits");

    credit_bounded: assert property (@(posedge CLK) disable iff (!rst_n)
        credit_cnt <= CREDIT_MAX)
        else $error("Credit count above its maximum");

    // CCR only moves on the edge that raises result_valid.
    ccr_held: assert property (@(posedge CLK) disable iff (!rst_n)
        !result_valid |-> $stable(ccr))
        else $error("ccr changed without a result");

endmodule

bind alu_core alu_core_properties props_i (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .op_valid      (op_valid),
    .op_ready      (op_ready),
    .result_credit (result_credit),
    .result_valid  (result_valid),
    .ccr           (ccr),
    .credit_cnt    (u_decode.credit_cnt)
);

/* dv/alu_tb.sv */
// ALU pipeline testbench
`timescale 1ns/1ps

module alu_tb;
    import alu_pkg::*;

    localparam int          CLK_PERIOD     = 100;
    localparam logic [31:0] LFSR_SEED      = 32'd36;
    localparam logic [31:0] LFSR_TAPS      = 32'hA300_0000;
    localparam int          MAX_OPS        = 300;
    localparam int          TIMEOUT_CYCLES = MAX_OPS * 20 + 200;

    logic     CLK;
    logic     rst_n;
    logic     op_valid;
    op_code_t op_code;
    op_size_t op_size;
    data_t    op_src;
    data_t    op_dst;
    cond_t    op_cond;
    logic     result_credit;
    logic     op_ready;
    logic     result_valid;
    data_t    result_data;
    ccr_t     ccr;

    data_t       exp_data_q[$];    // Expected results, acceptance order.
    ccr_t        exp_ccr_q[$];
    int          exp_cycle_q[$];   // Edge on which result_valid is due.
    ccr_t        model_ccr;
    logic [31:0] lfsr_state = LFSR_SEED;
    logic [1:0]  credit_pipe;
    logic        hold_credits;
    int          owed;
    int          cycle_cnt = 0;
    int          results_seen;
    int          checks;
    int          errors;

    alu_core dut_i (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_size       (op_size),
        .op_src        (op_src),
        .op_dst        (op_dst),
        .op_cond       (op_cond),
        .result_credit (result_credit),
        .op_ready      (op_ready),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .ccr           (ccr)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;
    always @(posedge CLK) cycle_cnt <= cycle_cnt + 1;

    // Galois LFSR, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic data_t bcd_byte();
        return data_t'({4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10)});
    endfunction

    // ==================================================================
    // Reference model
    // ==================================================================
    function automatic data_t model_op(input op_code_t code, input op_size_t size,
                                       input data_t src, input data_t dst,
                                       input cond_t cond, inout ccr_t f);
        int          w;
        int          da;
        int          db;
        int          dec;
        logic [63:0] mask;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic        xin;
        logic        c;
        logic        v;
        logic        n;
        logic        z;
        logic        ok;
        w    = (size == SIZE_BYTE) ? 8 : (size == SIZE_WORD) ? 16 : 32;
        mask = (64'd1 << w) - 64'd1;
        a    = 64'(dst) & mask;
        b    = 64'(src) & mask;
        xin  = (code == OP_ADDX || code == OP_SUBX) ? f[CCR_X] : 1'b0;
        c    = 1'b0;
        v    = 1'b0;
        if (code == OP_NEG) begin  // Zero minus dst.
            b = a;
            a = '0;
        end
        case (code)
            OP_ADD, OP_ADDX: begin
                r = a + b + 64'(xin);
                c = r[w];
                v = (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]);
            end
            OP_SUB, OP_SUBX, OP_CMP, OP_NEG: begin
                r = a - b - 64'(xin);
                c = (a < b + 64'(xin));  // Borrow.
                v = (a[w-1] != b[w-1]) && (r[w-1] != a[w-1]);
            end
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_EOR:  r = a ^ b;
            OP_NOT:  r = ~a;
            OP_MOVE: r = b;
            OP_ABCD, OP_SBCD: begin
                da  = 10 * int'(a[7:4]) + int'(a[3:0]);
                db  = 10 * int'(b[7:4]) + int'(b[3:0]);
                dec = (code == OP_ABCD) ? da + db + int'(f[CCR_X]) : da - db - int'(f[CCR_X]);
                c   = (dec > 99) || (dec < 0);
                dec = (dec + 100) % 100;
                r   = 64'(((dec / 10) << 4) | (dec % 10));
            end
            default: begin
                n = f[CCR_N];
                z = f[CCR_Z];
                v = f[CCR_V];
                c = f[CCR_C];
                case (cond)
                    4'd0:    ok = 1'b1;
                    4'd1:    ok = 1'b0;
                    4'd2:    ok = !c && !z;
                    4'd3:    ok = c || z;
                    4'd4:    ok = !c;
                    4'd5:    ok = c;
                    4'd6:    ok = !z;
                    4'd7:    ok = z;
                    4'd8:    ok = !v;
                    4'd9:    ok = v;
                    4'd10:   ok = !n;
                    4'd11:   ok = n;
                    4'd12:   ok = (n == v);
                    4'd13:   ok = (n != v);
                    4'd14:   ok = !z && (n == v);
                    default: ok = z || (n != v);
                endcase
                r = ok ? mask : '0;
            end
        endcase
        r = r & mask;
        n = r[w-1];
        z = (r == '0);
        case (code)
            OP_ADD, OP_SUB, OP_NEG:             f = {c, n, z, v, c};
            OP_ADDX, OP_SUBX:                   f = {c, n, z & f[CCR_Z], v, c};
            OP_CMP:                             f = {f[CCR_X], n, z, v, c};
            OP_AND, OP_OR, OP_EOR, OP_NOT, OP_MOVE: f = {f[CCR_X], n, z, 1'b0, 1'b0};
            OP_ABCD, OP_SBCD:                   f = {c, f[CCR_N], z & f[CCR_Z], f[CCR_V], c};
            default: ;                          // Scc.
        endcase
        return r[31:0];
    endfunction

    // ==================================================================
    // Stimulus
    // ==================================================================
    // Holds op_valid until op_ready, then queues the expected result.
    task automatic issue_op(input op_code_t code, input op_size_t size,
                            input data_t src, input data_t dst, input cond_t cond);
        data_t exp_data;
        exp_data = model_op(code, size, src, dst, cond, model_ccr);
        op_code  = code;
        op_size  = size;
        op_src   = src;
        op_dst   = dst;
        op_cond  = cond;
        op_valid = 1'b1;
        while (!op_ready) begin
            @(posedge CLK);
            #5;
        end
        exp_data_q.push_back(exp_data);
        exp_ccr_q.push_back(model_ccr);
        exp_cycle_q.push_back(cycle_cnt + 2);  // Edge after the acceptance edge.
        @(posedge CLK);
        #5;
        op_valid = 1'b0;
    endtask

    task automatic issue_random(input op_code_t code, input op_size_t size);
        issue_op(code, size, rand_bits(32), rand_bits(32), '0);
    endtask

    // Waits until every result is in and every credit is back.
    task automatic drain_results();
        while (exp_data_q.size() != 0 || owed != 0 || credit_pipe != '0 || result_credit) begin
            @(posedge CLK);
            #5;
        end
        @(posedge CLK);
        #5;
    endtask

    task automatic arith_sizes();
        op_code_t ops[4];
        ops = '{OP_ADD, OP_SUB, OP_CMP, OP_NEG};
        for (int s = 0; s < 3; s++) begin
            foreach (ops[i]) repeat (4) issue_random(ops[i], op_size_t'(s));
        end
    endtask

    task automatic extended_chains();
        for (int s = 0; s < 3; s++) begin
            issue_random(OP_ADD, op_size_t'(s));
            repeat (3) issue_random(OP_ADDX, op_size_t'(s));
            repeat (3) issue_random(OP_SUBX, op_size_t'(s));
            issue_op(OP_ADD, op_size_t'(s), 32'd0, 32'd0, '0);   // Z set, X clear.
            issue_op(OP_ADDX, op_size_t'(s), 32'd0, 32'd0, '0);  // Z kept.
            issue_op(OP_ADDX, op_size_t'(s), 32'd1, 32'd0, '0);  // Z cleared.
            issue_op(OP_SUBX, op_size_t'(s), 32'd0, 32'd0, '0);
        end
    endtask

    task automatic logic_and_move();
        op_code_t ops[5];
        ops = '{OP_AND, OP_OR, OP_EOR, OP_NOT, OP_MOVE};
        for (int s = 0; s < 3; s++) begin
            issue_random(OP_ADD, op_size_t'(s));  // Random X to be held.
            foreach (ops[i]) repeat (2) issue_random(ops[i], op_size_t'(s));
            issue_op(OP_MOVE, op_size_t'(s), 32'd0, rand_bits(32), '0);
        end
    endtask

    task automatic bcd_ops();
        data_t a;
        data_t b;
        for (int i = 0; i < 8; i++) begin
            a = bcd_byte();
            b = bcd_byte();
            issue_op(OP_ADD, SIZE_BYTE, data_t'(i % 2), 32'hFF, '0);  // X from i.
            issue_op(OP_ABCD, SIZE_BYTE, b, a, '0);
            issue_op(OP_ADD, SIZE_BYTE, data_t'(i % 2), 32'hFF, '0);
            issue_op(OP_SBCD, SIZE_BYTE, b, a, '0);
        end
    endtask

    task automatic scc_conditions();
        logic [19:0] setup[8];  // Code, dst, src.
        setup = '{{OP_ADD, 8'h00, 8'h00}, {OP_ADD, 8'h7F, 8'h01}, {OP_ADD, 8'hFF, 8'h01},
                  {OP_ADD, 8'h80, 8'h80}, {OP_ADD, 8'hFF, 8'h00}, {OP_ADD, 8'h01, 8'h01},
                  {OP_SUB, 8'h00, 8'h01}, {OP_ADD, 8'h80, 8'hFF}};
        for (int p = 0; p < 8; p++) begin
            issue_op(op_code_t'(setup[p][19:16]), SIZE_BYTE, data_t'(setup[p][7:0]),
                     data_t'(setup[p][15:8]), '0);
            for (int c = 0; c < 16; c++) begin
                issue_op(OP_SCC, op_size_t'(rand_bits(2) % 3), rand_bits(32), rand_bits(32),
                         cond_t'(c));
            end
        end
    endtask

    task automatic credit_stall();
        int base;
        drain_results();
        hold_credits = 1'b1;
        base = results_seen;
        issue_random(OP_ADD, SIZE_LONG);
        issue_random(OP_MOVE, SIZE_WORD);
        checks++;
        if (op_ready !== 1'b0) begin
            errors++;
            $display("** Error at %0t: op_ready got %b expected 0", $time, op_ready);
        end
        fork
            issue_random(OP_SUB, SIZE_BYTE);  // Stalls until a credit returns.
            begin
                repeat (6) begin
                    @(posedge CLK);
                    #5;
                    checks++;
                    if (op_ready !== 1'b0) begin
                        errors++;
                        $display("** Error at %0t: op_ready got %b expected 0", $time,
                                 op_ready);
                    end
                end
                checks++;
                if (results_seen - base != int'(CREDIT_MAX)) begin
                    errors++;
                    $display("** Error at %0t: result count got %0d expected %0d", $time,
                             results_seen - base, CREDIT_MAX);
                end
                hold_credits = 1'b0;
            end
        join
        issue_random(OP_EOR, SIZE_LONG);
        drain_results();
    endtask

    // ==================================================================
    // Result monitor and credit return
    // ==================================================================
    always @(posedge CLK) begin : result_monitor
        logic rv;
        #5;
        rv = rst_n && result_valid;
        if (rv) begin
            results_seen++;
            if (exp_data_q.size() == 0) begin
                errors++;
                $display("Unexpected result at %0t with no op outstanding", $time);
            end else begin
                checks += 3;
                if (result_data !== exp_data_q[0]) begin
                    errors++;
                    $display("** Error at %0t: result_data got %h expected %h", $time,
                             result_data, exp_data_q[0]);
                end
                if (ccr !== exp_ccr_q[0]) begin
                    errors++;
                    $display("** Error at %0t: ccr got %b expected %b", $time, ccr, exp_ccr_q[0]);
                end
                if (cycle_cnt != exp_cycle_q[0]) begin
                    errors++;
                    $display("** Error at %0t: result_valid edge got %0d expected %0d", $time,
                             cycle_cnt, exp_cycle_q[0]);
                end
                void'(exp_data_q.pop_front());
                void'(exp_ccr_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end
        owed += int'(credit_pipe[1]);  // Slot freed two cycles after the result.
        credit_pipe = {credit_pipe[0], rv};
        if (!hold_credits && owed > 0) begin
            result_credit = 1'b1;
            owed--;
        end else begin
            result_credit = 1'b0;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, %0d results still pending", TIMEOUT_CYCLES,
                 exp_data_q.size());
        $display("Results %0d, checks %0d, errors %0d", results_seen, checks, errors);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        op_valid      = 1'b0;
        op_code       = OP_ADD;
        op_size       = SIZE_BYTE;
        op_src        = '0;
        op_dst        = '0;
        op_cond       = '0;
        result_credit = 1'b0;
        rst_n         = 1'b0;
        model_ccr     = '0;
        credit_pipe   = '0;
        hold_credits  = 1'b0;
        owed          = 0;
        results_seen  = 0;
        checks        = 0;
        errors        = 0;
        repeat (4) @(posedge CLK);
        #5;
        rst_n = 1'b1;
        checks += 4;
        if (op_ready !== 1'b1) begin
            errors++;
            $display("** Error at %0t: op_ready got %b expected 1", $time, op_ready);
        end
        if (result_valid !== 1'b0) begin
            errors++;
            $display("** Error at %0t: result_valid got %b expected 0", $time, result_valid);
        end
        if (ccr !== '0) begin
            errors++;
            $display("** Error at %0t: ccr got %b expected 00000", $time, ccr);
        end
        if (result_data !== '0) begin
            errors++;
            $display("** Error at %0t: result_data got %h expected 00000000", $time,
                     result_data);
        end
        arith_sizes();
        extended_chains();
        logic_and_move();
        bcd_ops();
        scc_conditions();
        credit_stall();
        drain_results();
        $display("Results %0d, checks %0d, errors %0d", results_seen, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
design/alu_pkg.sv
design/alu_issue_if.sv
design/alu_commit_if.sv
design/alu_decode.sv
design/alu_execute.sv
design/alu_result.sv
design/alu_core.sv
dv/alu_core_properties.sv
dv/alu_tb.sv
